//--- source/ram_loader_cfg.svh
`ifndef RAM_LOADER_CFG_SVH
`define RAM_LOADER_CFG_SVH

// Memory geometry
`define RAM_ADDR_W 10
`define RAM_DEPTH 1024
`define NB_COL 4
`define COL_W 8

// Clock cycles per serial bit
`define CLKS_PER_BIT 16

// Unlock sequence sent ahead of a program image
`define PROG_SEQ "PROG"
`define PROG_SEQ_LEN 4

// Idle cycles that drop a partial unlock sequence
`define SEQ_BREAK_CYCLES 400

`endif

//--- source/ram_loader_pkg.sv
`include "ram_loader_cfg.svh"

package ram_loader_pkg;

  //////////////////////////////
  // Memory types
  //////////////////////////////

  typedef logic [`NB_COL*`COL_W-1:0] word_t;
  typedef logic [`RAM_ADDR_W-1:0] addr_t;
  typedef logic [`NB_COL-1:0] strb_t;

  // One byte off the serial line
  typedef logic [7:0] byte_t;

  //////////////////////////////
  // Loader FSM
  //////////////////////////////

  typedef enum logic [2:0] {
    ST_WAIT,
    ST_RECEIVE,
    ST_CHECK,
    ST_COUNT,
    ST_PROGRAM,
    ST_FINISH
  } loader_state_e;

endpackage

//--- source/ram_prog_if.sv
interface ram_prog_if import ram_loader_pkg::*; ();

  // Write traffic from the serial loader into the RAM
  logic  prog_valid;
  addr_t prog_addr;
  word_t prog_data;
  logic  prog_mode;

  modport loader (
    output prog_valid,
    output prog_addr,
    output prog_data,
    output prog_mode
  );

  modport ram (
    input prog_valid,
    input prog_addr,
    input prog_data,
    input prog_mode
  );

endinterface

//--- source/uart_byte_rx.sv
`include "ram_loader_cfg.svh"

module uart_byte_rx import ram_loader_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rx_i,
  output byte_t byte_o,
  output logic  valid_o
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             busy_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [3:0]       bit_idx_q;
  byte_t            shift_q;
  logic             valid_q;

  // Line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////
  // Bit timing
  //////////////////////////////

  // Bit index 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (!rx_sync_q) begin
          // First sample lands mid start bit
          busy_q    <= 1'b1;
          clk_cnt_q <= CNT_W'(`CLKS_PER_BIT / 2 - 1);
          bit_idx_q <= '0;
        end
      end else if (clk_cnt_q == '0) begin
        clk_cnt_q <= CNT_W'(`CLKS_PER_BIT - 1);
        bit_idx_q <= bit_idx_q + 4'd1;
        if (bit_idx_q == 4'd0 && rx_sync_q) begin
          // Start bit gone high again by its centre
          busy_q <= 1'b0;
        end else if (bit_idx_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rx_sync_q;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q - CNT_W'(1);
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (busy_q && clk_cnt_q == '0 && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o  = shift_q;
  assign valid_o = valid_q;

  a_single_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o);

endmodule

//--- source/prog_loader.sv
`include "ram_loader_cfg.svh"

module prog_loader import ram_loader_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  byte_t rx_byte_i,
  input  logic  rx_valid_i,
  ram_prog_if.loader prog,
  output logic  system_reset_no
);

  localparam int SEQ_CNT_W = $clog2(`PROG_SEQ_LEN);
  localparam int BRK_W = $clog2(`SEQ_BREAK_CYCLES + 1);
  localparam int SEQ_W = `PROG_SEQ_LEN * 8;

  loader_state_e        state_q;
  loader_state_e        state_d;
  logic [SEQ_W-1:0]     seq_q;
  logic [SEQ_CNT_W-1:0] seq_cnt_q;
  logic [BRK_W-1:0]     brk_cnt_q;
  logic [1:0]           byte_cnt_q;
  word_t                count_q;
  word_t                count_nxt;
  word_t                words_q;
  word_t                data_q;
  word_t                data_nxt;
  addr_t                addr_q;
  logic                 valid_q;
  logic                 rst_n_q;

  // Big-endian assembly with the newest byte at the bottom
  assign count_nxt = {count_q[$bits(word_t)-9:0], rx_byte_i};
  assign data_nxt  = {data_q[$bits(word_t)-9:0], rx_byte_i};

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_WAIT: begin
        if (rx_valid_i) begin
          state_d = ST_RECEIVE;
        end
      end
      ST_RECEIVE: begin
        if (rx_valid_i) begin
          if (seq_cnt_q == SEQ_CNT_W'(`PROG_SEQ_LEN - 1)) begin
            state_d = ST_CHECK;
          end
        end else if (brk_cnt_q == BRK_W'(`SEQ_BREAK_CYCLES)) begin
          state_d = ST_WAIT;
        end
      end
      ST_CHECK: begin
        state_d = (seq_q == `PROG_SEQ) ? ST_COUNT : ST_WAIT;
      end
      ST_COUNT: begin
        if (rx_valid_i && &byte_cnt_q) begin
          state_d = (count_nxt == '0) ? ST_FINISH : ST_PROGRAM;
        end
      end
      ST_PROGRAM: begin
        // Counter catches up while the last word is being written
        if (words_q == count_q) begin
          state_d = ST_FINISH;
        end
      end
      default: state_d = ST_WAIT;
    endcase
  end

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= ST_WAIT;
      seq_cnt_q  <= '0;
      brk_cnt_q  <= '0;
      byte_cnt_q <= '0;
      words_q    <= '0;
      addr_q     <= '0;
      valid_q    <= 1'b0;
      rst_n_q    <= 1'b1;
    end else begin
      state_q <= state_d;
      valid_q <= 1'b0;
      rst_n_q <= (state_q != ST_FINISH);
      case (state_q)
        ST_WAIT: begin
          seq_cnt_q  <= rx_valid_i ? SEQ_CNT_W'(1) : '0;
          brk_cnt_q  <= '0;
          byte_cnt_q <= '0;
          words_q    <= '0;
          addr_q     <= '0;
        end
        ST_RECEIVE: begin
          if (rx_valid_i) begin
            seq_cnt_q <= seq_cnt_q + SEQ_CNT_W'(1);
            brk_cnt_q <= '0;
          end else begin
            brk_cnt_q <= brk_cnt_q + BRK_W'(1);
          end
        end
        ST_COUNT: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
          end
        end
        ST_PROGRAM: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (&byte_cnt_q) begin
              valid_q <= 1'b1;
              words_q <= words_q + 1'b1;
            end
          end
          if (valid_q) begin
            addr_q <= addr_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Byte payload
  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      case (state_q)
        ST_WAIT, ST_RECEIVE: seq_q <= {seq_q[SEQ_W-9:0], rx_byte_i};
        ST_COUNT: count_q <= count_nxt;
        ST_PROGRAM: data_q <= data_nxt;
        default: ;
      endcase
    end
  end

  assign prog.prog_valid = valid_q;
  assign prog.prog_addr  = addr_q;
  assign prog.prog_data  = data_q;
  assign prog.prog_mode  = (state_q == ST_PROGRAM);
  assign system_reset_no = rst_n_q;

  a_valid_in_mode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prog.prog_valid |-> prog.prog_mode);

  a_reset_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !system_reset_no |=> system_reset_no);

endmodule

//--- source/byte_write_ram.sv
`include "ram_loader_cfg.svh"

module byte_write_ram import ram_loader_pkg::*; (
  input  logic  clk_i,
  input  addr_t wr_addr_i,
  input  word_t wr_data_i,
  input  strb_t wr_strb_i,
  input  logic  rd_en_i,
  input  addr_t rd_addr_i,
  output word_t rd_data_o,
  ram_prog_if.ram prog
);

  word_t mem [`RAM_DEPTH];
  word_t rd_q;
  logic  prog_wr;
  addr_t wr_addr;
  word_t wr_data;

  // Memory starts cleared in simulation
  initial begin
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////
  // Write port
  //////////////////////////////

  // Loader wins a write collision and the host write is dropped
  assign prog_wr = prog.prog_valid && prog.prog_mode;
  assign wr_addr = prog_wr ? prog.prog_addr : wr_addr_i;
  assign wr_data = prog_wr ? prog.prog_data : wr_data_i;

  for (genvar lane = 0; lane < `NB_COL; lane++) begin : g_lane
    always_ff @(posedge clk_i) begin
      if (prog_wr || wr_strb_i[lane]) begin
        mem[wr_addr][lane*`COL_W +: `COL_W] <= wr_data[lane*`COL_W +: `COL_W];
      end
    end
  end

  // Registered read that holds when not enabled
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_q <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_q;

endmodule

//--- source/prog_ram_top.sv
module prog_ram_top import ram_loader_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Host port
  input  addr_t host_wr_addr_i,
  input  word_t host_wr_data_i,
  input  strb_t host_wr_strb_i,
  input  logic  host_rd_en_i,
  input  addr_t host_rd_addr_i,
  output word_t host_rd_data_o,

  // Serial loader
  input  logic  prog_rx_i,
  output logic  system_reset_no,
  output logic  prog_mode_o
);

  byte_t rx_byte;
  logic  rx_valid;

  ram_prog_if prog_bus ();

  uart_byte_rx i_uart_byte_rx (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rx_i    (prog_rx_i),
    .byte_o  (rx_byte),
    .valid_o (rx_valid)
  );

  prog_loader i_prog_loader (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_byte_i       (rx_byte),
    .rx_valid_i      (rx_valid),
    .prog            (prog_bus.loader),
    .system_reset_no (system_reset_no)
  );

  byte_write_ram i_byte_write_ram (
    .clk_i     (clk_i),
    .wr_addr_i (host_wr_addr_i),
    .wr_data_i (host_wr_data_i),
    .wr_strb_i (host_wr_strb_i),
    .rd_en_i   (host_rd_en_i),
    .rd_addr_i (host_rd_addr_i),
    .rd_data_o (host_rd_data_o),
    .prog      (prog_bus.ram)
  );

  assign prog_mode_o = prog_bus.prog_mode;

endmodule

//--- tb/prog_ram_tb.sv
`include "ram_loader_cfg.svh"

module prog_ram_tb import ram_loader_pkg::*; ();

  localparam string VEC_FILE = "tb/prog_ram_vectors.txt";
  localparam int RESET_CYCLES = 16;
  localparam int LIMIT_MARGIN = 2000;

  logic  clk_i;
  logic  rst_ni;
  addr_t host_wr_addr;
  word_t host_wr_data;
  strb_t host_wr_strb;
  logic  host_rd_en;
  addr_t host_rd_addr;
  word_t host_rd_data;
  logic  prog_rx;
  logic  system_reset_n;
  logic  prog_mode;

  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  int unsigned pulse_cnt = 0;
  int unsigned mode_cnt = 0;
  int unsigned pulse_base;
  int unsigned mode_base;
  int unsigned test_errs;
  int unsigned err_total;
  int unsigned tests_passed;
  int unsigned tests_failed;
  string       test_name;
  word_t       model [addr_t];

  // Last command read from the vector file
  string       tok;
  byte         cmd;
  string       arg_name;
  logic [31:0] arg_a;
  logic [31:0] arg_b;
  logic [31:0] arg_c;

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  prog_ram_top i_prog_ram_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .host_wr_addr_i  (host_wr_addr),
    .host_wr_data_i  (host_wr_data),
    .host_wr_strb_i  (host_wr_strb),
    .host_rd_en_i    (host_rd_en),
    .host_rd_addr_i  (host_rd_addr),
    .host_rd_data_o  (host_rd_data),
    .prog_rx_i       (prog_rx),
    .system_reset_no (system_reset_n),
    .prog_mode_o     (prog_mode)
  );

  //////////////////////////////
  // Monitors and watchdog
  //////////////////////////////

  // Sampled before the edge updates the DUT flops
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_ni && system_reset_n === 1'b0) begin
      pulse_cnt <= pulse_cnt + 1;
    end
    if (rst_ni && prog_mode === 1'b1) begin
      mode_cnt <= mode_cnt + 1;
    end
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic count_error();
    test_errs++;
    err_total++;
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_count(input string what, input int unsigned exp,
                             input int unsigned act);
    if (act != exp) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      count_error();
    end
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////

  // 8N1 frame with the start bit first and data LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      prog_rx = frame[i];
      repeat (`CLKS_PER_BIT - 1) @(negedge clk_i);
    end
  endtask

  // Big-endian on the line
  task automatic send_word(input word_t w);
    for (int k = `NB_COL - 1; k >= 0; k--) begin
      send_byte(w[k*8 +: 8]);
    end
  endtask

  task automatic host_write(input addr_t a, input word_t d, input strb_t s);
    @(negedge clk_i);
    host_wr_addr = a;
    host_wr_data = d;
    host_wr_strb = s;
    @(negedge clk_i);
    host_wr_strb = '0;
  endtask

  task automatic host_read(input addr_t a, output word_t d);
    @(negedge clk_i);
    host_rd_en   = 1'b1;
    host_rd_addr = a;
    @(negedge clk_i);
    host_rd_en = 1'b0;
    d = host_rd_data;
  endtask

  // Expected word after a host write with lanes taken under their strobe
  function automatic word_t merge_strobes(word_t old_w, word_t new_w, strb_t s);
    word_t r;
    r = old_w;
    for (int l = 0; l < `NB_COL; l++) begin
      if (s[l]) begin
        r[l*`COL_W +: `COL_W] = new_w[l*`COL_W +: `COL_W];
      end
    end
    return r;
  endfunction

  function automatic word_t model_word(addr_t a);
    return model.exists(a) ? model[a] : '0;
  endfunction

  task automatic wait_for_pulses(input int unsigned n);
    while (pulse_cnt - pulse_base < n) begin
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Vector file
  //////////////////////////////

  // Skips comment lines and reads one command with its operands
  task automatic read_command(input int fd, output bit got);
    int               code;
    logic [8*160-1:0] rest;
    got = 1'b0;
    forever begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        return;
      end
      if (tok[0] != "#") begin
        break;
      end
      code = $fgets(rest, fd);
    end
    got = 1'b1;
    cmd = tok[0];
    case (cmd)
      "t": code = $fscanf(fd, "%s", arg_name);
      "b", "q", "m": code = $fscanf(fd, "%h", arg_a);
      "i": code = $fscanf(fd, "%d", arg_a);
      "r": code = $fscanf(fd, "%h %h", arg_a, arg_b);
      "p": code = $fscanf(fd, "%d %d", arg_a, arg_b);
      "w": code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
      default: ;
    endcase
  endtask

  // Line time of every byte plus all idle gaps
  task automatic compute_cycle_limit(input int fd);
    bit          got;
    int unsigned total;
    total = LIMIT_MARGIN;
    forever begin
      read_command(fd, got);
      if (!got) begin
        break;
      end
      case (cmd)
        "b": total += 10 * `CLKS_PER_BIT;
        "q": total += `NB_COL * 10 * `CLKS_PER_BIT;
        "i": total += arg_a;
        default: ;
      endcase
    end
    cycle_limit = total;
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_errs  = 0;
    pulse_base = pulse_cnt;
    mode_base  = mode_cnt;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("Test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d mismatches", test_name, test_errs);
    end
  endtask

  task automatic run_vectors(input int fd);
    bit    got;
    addr_t a;
    word_t rd;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("system_reset_no", 1'b1, system_reset_n);
    check_flag("prog_mode_o", 1'b0, prog_mode);
    forever begin
      read_command(fd, got);
      if (!got) begin
        break;
      end
      a = addr_t'(arg_a);
      case (cmd)
        "t": begin
          finish_test();
          start_test(arg_name);
        end
        "b": send_byte(arg_a[7:0]);
        "q": send_word(arg_a);
        "i": repeat (arg_a) @(negedge clk_i);
        "w": begin
          host_write(a, arg_b, strb_t'(arg_c));
          model[a] = merge_strobes(model_word(a), arg_b, strb_t'(arg_c));
        end
        "r": begin
          host_read(a, rd);
          check_word($sformatf("read %h", a), arg_b, rd);
        end
        "m": begin
          host_read(a, rd);
          check_word($sformatf("merged read %h", a), model_word(a), rd);
        end
        "p": begin
          wait_for_pulses(arg_a);
          // Cover the cycle after the pulse so a stretched pulse is counted
          @(negedge clk_i);
          check_count("reset pulses", arg_a, pulse_cnt - pulse_base);
          check_flag("prog mode seen", arg_b[0], mode_cnt != mode_base);
        end
        default: begin
          $display("Unknown command %c in the vector file", cmd);
          count_error();
        end
      endcase
    end
    $fclose(fd);
    finish_test();
    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, err_total);
    if (tests_failed == 0 && err_total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    int fd;
    rst_ni       = 1'b0;
    host_wr_addr = '0;
    host_wr_data = '0;
    host_wr_strb = '0;
    host_rd_en   = 1'b0;
    host_rd_addr = '0;
    prog_rx      = 1'b1;
    err_total    = 0;
    tests_passed = 0;
    tests_failed = 0;
    start_test("power_up");
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the vector file %s", VEC_FILE);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      compute_cycle_limit(fd);
      $fclose(fd);
      fd = $fopen(VEC_FILE, "r");
      run_vectors(fd);
    end
  end

endmodule

//--- tb/prog_ram_vectors.txt
# t name | b byte | q word sent MSB first | i idle cycles (dec) | m addr (read vs strobe model)
# w addr data strb | r addr expected | p reset_pulses mode_seen (dec) | other values hex
t reset_reads
r 000 00000000
r 3ff 00000000
r 155 00000000
p 0 0
t full_load
q 50524f47
q 00000003
q 11223344
q a5a55a5a
q deadbeef
p 1 1
r 000 11223344
r 001 a5a55a5a
r 002 deadbeef
r 003 00000000
t bad_sequence
q 50524f48
q 01020304
q 05060708
i 600
p 0 0
r 000 11223344
r 001 a5a55a5a
t break_gap
b 50
b 52
i 500
q 50524f47
q 00000001
q cafef00d
p 1 1
r 000 cafef00d
r 001 a5a55a5a
t byte_strobes
w 100 12345678 f
m 100
w 100 aabbccdd 5
m 100
w 100 99887766 8
m 100
w 101 0badc0de 3
m 101
t zero_count
q 50524f47
q 00000000
p 1 0
r 000 cafef00d

//--- filelist.f
+incdir+source
source/ram_loader_pkg.sv
source/ram_prog_if.sv
source/uart_byte_rx.sv
source/prog_loader.sv
source/byte_write_ram.sv
source/prog_ram_top.sv
tb/prog_ram_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= prog_ram_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VECTORS   ?= tb/prog_ram_vectors.txt
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(wildcard source/*.sv source/*.svh tb/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(VECTORS)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
